// File: rtl/address_mapper.sv
`timescale 1ns/1ns

module address_mapper (
   input  zxmem_pkg::cpu_bus_t       cpu,
   input  zxmem_pkg::paging_state_t  state,
   output zxmem_pkg::sram_req_t      req,
   output logic                      access_to_screen
);
   import zxmem_pkg::*;

   logic [1:0]            slot;         // 16 KB slot of the cpu address
   logic                  boot_mode;
   logic                  allram;       // +3 special paging
   logic [1:0]            arrangement;
   logic [2:0]            ram_bank;     // page at c000 in normal paging
   logic [1:0]            rom_sel;
   logic [PAGE_NUM_W-1:0] page;
   logic                  served;       // sram answers this cycle
   logic                  wr_block;     // rom area, no writes

   // 128K ram page as a full sram page number
   function automatic logic [PAGE_NUM_W-1:0] ram_page(input logic [2:0] p);
      return {{(PAGE_NUM_W-3){1'b0}}, p};
   endfunction

   always_comb begin
      slot        = cpu.a[15:14];
      boot_mode   = state.masterconf[MC_BOOT_BIT];
      allram      = state.bankplus3[PLUS3_ALLRAM_BIT];
      arrangement = state.bankplus3[2:1];
      ram_bank    = state.bank128[2:0];
      rom_sel     = {state.bankplus3[2], state.bank128[4]};
   end

   //------------------------------------------------------------
   // page selection per slot
   //------------------------------------------------------------
   always_comb begin
      page     = '0;
      served   = 1'b1;
      wr_block = 1'b0;
      case (slot)
         2'b00: begin                            // 0000-3fff
            if (boot_mode) begin
               served = 1'b0;                    // boot rom area, not in sram
            end else if (!allram) begin
               page     = {ROM_PAGE_BASE, rom_sel};
               wr_block = 1'b1;                  // rom is read only
            end else if (arrangement == 2'b00) begin
               page = ram_page(RAM_PAGE_0);
            end else begin
               page = ram_page(RAM_PAGE_4);
            end
         end
         2'b01: begin                            // 4000-7fff
            if (boot_mode || !allram) begin
               page = ram_page(RAM_PAGE_5);
            end else begin
               case (arrangement)
                  2'b00:   page = ram_page(RAM_PAGE_1);
                  2'b11:   page = ram_page(RAM_PAGE_7);
                  default: page = ram_page(RAM_PAGE_5);
               endcase
            end
         end
         2'b10: begin                            // 8000-bfff
            if (boot_mode || !allram || arrangement == 2'b00) begin
               page = ram_page(RAM_PAGE_2);
            end else begin
               page = ram_page(RAM_PAGE_6);
            end
         end
         default: begin                          // c000-ffff
            if (boot_mode) begin
               page = state.mastermapper;        // any of the 32 pages
            end else if (!allram) begin
               page = ram_page(ram_bank);
            end else if (arrangement == 2'b01) begin
               page = ram_page(RAM_PAGE_7);
            end else begin
               page = ram_page(RAM_PAGE_3);
            end
         end
      endcase
   end

   //------------------------------------------------------------
   // sram request
   //------------------------------------------------------------
   always_comb begin
      req.addr = '0;
      if (!cpu.mreq_n) begin
         req.addr = {page, cpu.a[PAGE_OFS_W-1:0]};
      end
      req.oe_n = cpu.mreq_n || cpu.rd_n || !served;
      req.we_n = cpu.mreq_n || cpu.wr_n || !served || wr_block;
   end

   // contention only with normal 128K paging, slot 1 or a screen page at c000
   always_comb begin
      access_to_screen = 1'b0;
      if (!boot_mode && !allram) begin
         if (slot == 2'b01) begin
            access_to_screen = 1'b1;
         end else if (slot == 2'b11 &&
                      (ram_bank == SCREEN_PAGE_A || ram_bank == SCREEN_PAGE_B)) begin
            access_to_screen = 1'b1;
         end
      end
   end

endmodule

// File: rtl/cpu_data_mux.sv
`timescale 1ns/1ns

module cpu_data_mux (
   input  zxmem_pkg::cpu_bus_t       cpu,
   input  zxmem_pkg::zxreg_bus_t     zxreg,
   input  logic                      rd_masterconf,
   input  logic                      rd_mastermapper,
   input  zxmem_pkg::paging_state_t  state,
   input  zxmem_pkg::sram_req_t      req,
   input  logic [7:0]                sram_rdata,
   output logic [7:0]                dout,
   output logic                      oe_n
);
   import zxmem_pkg::*;

   logic mem_rd;   // memory read served by the sram
   logic reg_rd;   // zx-uno register read in progress

   always_comb begin
      mem_rd = !req.oe_n && !cpu.rd_n;
      reg_rd = zxreg.ior;
   end

   //------------------------------------------------------------
   // data back to the cpu, memory first then registers
   //------------------------------------------------------------
   always_comb begin
      dout = 8'h00;
      oe_n = 1'b1;   // nothing to drive
      if (mem_rd) begin
         dout = sram_rdata;
         oe_n = 1'b0;
      end else if (reg_rd && rd_masterconf) begin
         dout = state.masterconf;
         oe_n = 1'b0;
      end else if (reg_rd && rd_mastermapper) begin
         dout = {{(8-PAGE_NUM_W){1'b0}}, state.mastermapper};  // zero padded
         oe_n = 1'b0;
      end
   end

endmodule

// File: rtl/io_port_decode.sv
`timescale 1ns/1ns

module io_port_decode (
   input  zxmem_pkg::cpu_bus_t     cpu,
   input  zxmem_pkg::zxreg_bus_t   zxreg,
   input  zxmem_pkg::port_opts_t   opts,
   input  logic                    port_locked,
   input  logic                    boot_mode,
   output zxmem_pkg::io_strobes_t  strobes,
   output logic                    ioreqbank
);
   import zxmem_pkg::*;

   logic io_cycle;        // real i/o cycle, not an interrupt acknowledge
   logic io_wr;
   logic io_acc;
   logic hit_7ffd_sp128;
   logic hit_7ffd_plus2a;
   logic hit_1ffd;
   logic style_sp128;
   logic style_plus2a;

   //------------------------------------------------------------
   // paging ports, partial decode
   //------------------------------------------------------------
   always_comb begin
      io_cycle = !cpu.iorq_n && cpu.m1_n;
      io_wr    = io_cycle && !cpu.wr_n;
      io_acc   = io_cycle && (!cpu.wr_n || !cpu.rd_n);

      hit_7ffd_sp128  = !cpu.a[1] && !cpu.a[15];               // 128K style
      hit_7ffd_plus2a = !cpu.a[1] && (cpu.a[15:14] == 2'b01);  // +2A style
      hit_1ffd        = !cpu.a[1] && (cpu.a[15:12] == 4'b0001);

      // disable_7ffd kills both ports
      style_sp128  = !opts.disable_7ffd && opts.disable_1ffd;
      style_plus2a = !opts.disable_7ffd && !opts.disable_1ffd;

      strobes.wr_7ffd = io_wr && !port_locked &&
                        ((style_sp128  && hit_7ffd_sp128) ||
                         (style_plus2a && hit_7ffd_plus2a));
      strobes.wr_1ffd = io_wr && !port_locked && style_plus2a && hit_1ffd;

      // bank port access flag, the lock bit does not matter here
      ioreqbank = io_acc && style_sp128 && hit_7ffd_sp128;
   end

   //------------------------------------------------------------
   // zx-uno register numbers
   //------------------------------------------------------------
   always_comb begin
      strobes.wr_masterconf   = zxreg.iow && (zxreg.addr == REG_ADDR_MASTERCONF);
      strobes.wr_mastermapper = zxreg.iow && (zxreg.addr == REG_ADDR_MASTERMAPPER)
                                && boot_mode;   // mapper is only writable while booting
      strobes.rd_masterconf   = zxreg.ior && (zxreg.addr == REG_ADDR_MASTERCONF);
      strobes.rd_mastermapper = zxreg.ior && (zxreg.addr == REG_ADDR_MASTERMAPPER);
   end

endmodule

// File: rtl/paging_regs.sv
`timescale 1ns/1ns

module paging_regs (
   input  logic                      clk,
   input  logic                      mrst_n,
   input  logic [7:0]                din,
   input  zxmem_pkg::io_strobes_t    strobes,
   output zxmem_pkg::paging_state_t  state
);
   import zxmem_pkg::*;

   logic [7:0]            bank128;       // port 7ffd
   logic [7:0]            bankplus3;     // port 1ffd
   logic [7:0]            masterconf;
   logic [PAGE_NUM_W-1:0] mastermapper;  // page seen at c000 while booting

   //------------------------------------------------------------
   // masterconf
   //------------------------------------------------------------
   // bits 6..3 are timing and keyboard options, always writable
   // bit 7 and bits 2..0 lock once the freeze bit is set
   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         masterconf <= MASTERCONF_RST;
      end else if (strobes.wr_masterconf) begin
         masterconf[6:3] <= din[6:3];
         if (!masterconf[MC_FROZEN_BIT]) begin
            masterconf[7]   <= din[7];
            masterconf[2:0] <= din[2:0];   // boot mode bit lives here
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         mastermapper <= '0;
      end else if (strobes.wr_mastermapper) begin
         mastermapper <= din[PAGE_NUM_W-1:0];
      end
   end

   //------------------------------------------------------------
   // 128K / +3 paging ports
   //------------------------------------------------------------
   // lock handling is done in the decoder, here a strobe just loads
   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         bank128   <= 8'h00;
         bankplus3 <= 8'h00;
      end else begin
         if (strobes.wr_7ffd) begin
            bank128 <= din;
         end
         if (strobes.wr_1ffd) begin
            bankplus3 <= din;
         end
      end
   end

   always_comb begin
      state.bank128      = bank128;
      state.bankplus3    = bankplus3;
      state.masterconf   = masterconf;
      state.mastermapper = mastermapper;
   end

endmodule

// File: rtl/zxmem_pkg.sv
package zxmem_pkg;

   //------------------------------------------------------------
   // widths and register numbers
   //------------------------------------------------------------
   localparam int SRAM_AW    = 19;   // 512 KB external SRAM
   localparam int PAGE_OFS_W = 14;   // offset inside a 16 KB page
   localparam int PAGE_NUM_W = 5;    // 32 pages of 16 KB

   localparam logic [7:0] REG_ADDR_MASTERCONF   = 8'h00;
   localparam logic [7:0] REG_ADDR_MASTERMAPPER = 8'h01;

   // 128K ram pages, sram pages 0 to 7
   localparam logic [2:0] RAM_PAGE_0 = 3'd0;
   localparam logic [2:0] RAM_PAGE_1 = 3'd1;
   localparam logic [2:0] RAM_PAGE_2 = 3'd2;
   localparam logic [2:0] RAM_PAGE_3 = 3'd3;
   localparam logic [2:0] RAM_PAGE_4 = 3'd4;
   localparam logic [2:0] RAM_PAGE_5 = 3'd5;
   localparam logic [2:0] RAM_PAGE_6 = 3'd6;
   localparam logic [2:0] RAM_PAGE_7 = 3'd7;

   localparam logic [2:0] ROM_PAGE_BASE = 3'b010;  // roms live in sram pages 8..11

   // pages shared with the ula, these get contended
   localparam logic [2:0] SCREEN_PAGE_A = 3'd5;
   localparam logic [2:0] SCREEN_PAGE_B = 3'd7;

   //------------------------------------------------------------
   // bit positions inside the registers
   //------------------------------------------------------------
   localparam int MC_FROZEN_BIT    = 7;
   localparam int MC_TIMING_HI_BIT = 6;
   localparam int MC_NOCONT_BIT    = 5;
   localparam int MC_TIMING_LO_BIT = 4;
   localparam int MC_ISSUE2_BIT    = 3;
   localparam int MC_BOOT_BIT      = 0;

   localparam int BANK128_LOCK_BIT = 5;   // 7ffd bit 5 locks both paging ports
   localparam int PLUS3_ALLRAM_BIT = 0;   // 1ffd bit 0 selects all-ram mode

   localparam logic [7:0] MASTERCONF_RST = 8'h01;  // boot mode, not frozen

   //------------------------------------------------------------
   // buses and state
   //------------------------------------------------------------
   typedef struct packed {
      logic [15:0] a;
      logic [7:0]  din;      // data from cpu
      logic        mreq_n;
      logic        iorq_n;
      logic        rd_n;
      logic        wr_n;
      logic        m1_n;
   } cpu_bus_t;

   typedef struct packed {
      logic [7:0] addr;      // zx-uno register number
      logic       ior;
      logic       iow;
   } zxreg_bus_t;

   typedef struct packed {
      logic disable_7ffd;
      logic disable_1ffd;    // set means sp128 style decode
   } port_opts_t;

   typedef struct packed {
      logic wr_7ffd;
      logic wr_1ffd;
      logic wr_masterconf;
      logic wr_mastermapper;
      logic rd_masterconf;
      logic rd_mastermapper;
   } io_strobes_t;

   typedef struct packed {
      logic [7:0]            bank128;
      logic [7:0]            bankplus3;
      logic [7:0]            masterconf;
      logic [PAGE_NUM_W-1:0] mastermapper;
   } paging_state_t;

   typedef struct packed {
      logic [SRAM_AW-1:0] addr;
      logic               we_n;
      logic               oe_n;   // sram byte goes back to the cpu
   } sram_req_t;

endpackage

// File: rtl/zxmem_top.sv
`timescale 1ns/1ns

module zxmem_top (
   input  logic                   clk,
   input  logic                   mrst_n,
   input  zxmem_pkg::cpu_bus_t    cpu,
   input  zxmem_pkg::zxreg_bus_t  zxreg,
   input  zxmem_pkg::port_opts_t  opts,
   output logic [7:0]             dout,
   output logic                   oe_n,
   output logic [18:0]            sram_addr,
   output logic                   sram_we_n,
   output logic [7:0]             sram_wdata,
   input  logic [7:0]             sram_rdata,
   output logic                   ioreqbank,
   output logic                   access_to_screen,
   output logic                   in_boot_mode,
   output logic [1:0]             timing_mode,
   output logic                   disable_contention,
   output logic                   issue2_keyboard_enabled
);
   import zxmem_pkg::*;

   io_strobes_t   strobes;
   paging_state_t state;
   sram_req_t     req;

   io_port_decode u_decode (
      .cpu         (cpu),
      .zxreg       (zxreg),
      .opts        (opts),
      .port_locked (state.bank128[BANK128_LOCK_BIT]),
      .boot_mode   (state.masterconf[MC_BOOT_BIT]),
      .strobes     (strobes),
      .ioreqbank   (ioreqbank)
   );

   paging_regs u_regs (
      .clk     (clk),
      .mrst_n  (mrst_n),
      .din     (cpu.din),
      .strobes (strobes),
      .state   (state)
   );

   address_mapper u_mapper (
      .cpu              (cpu),
      .state            (state),
      .req              (req),
      .access_to_screen (access_to_screen)
   );

   cpu_data_mux u_dmux (
      .cpu             (cpu),
      .zxreg           (zxreg),
      .rd_masterconf   (strobes.rd_masterconf),
      .rd_mastermapper (strobes.rd_mastermapper),
      .state           (state),
      .req             (req),
      .sram_rdata      (sram_rdata),
      .dout            (dout),
      .oe_n            (oe_n)
   );

   // sram side
   assign sram_addr  = req.addr;
   assign sram_we_n  = req.we_n;
   assign sram_wdata = cpu.din;   // only sampled by the sram while we_n is low

   // configuration seen by the ula and keyboard
   assign in_boot_mode            = state.masterconf[MC_BOOT_BIT];
   assign timing_mode             = {state.masterconf[MC_TIMING_HI_BIT],
                                     state.masterconf[MC_TIMING_LO_BIT]};
   assign disable_contention      = state.masterconf[MC_NOCONT_BIT];
   assign issue2_keyboard_enabled = state.masterconf[MC_ISSUE2_BIT];

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the zxmem testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module zxmem_tb -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vzxmem_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" sim.log; then
   exit 1
fi
exit 0

// File: tb.f
rtl/zxmem_pkg.sv
rtl/io_port_decode.sv
rtl/paging_regs.sv
rtl/address_mapper.sv
rtl/cpu_data_mux.sv
rtl/zxmem_top.sv
tests/tb_clock_gen.sv
tests/zxmem_checker.sv
tests/zxmem_tb.sv

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
   output logic clk,
   output logic mrst_n
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   // reset held low over the first 10 rising edges
   initial begin
      mrst_n <= 1'b0;
      repeat (10) @(posedge clk);
      mrst_n <= 1'b1;
   end

endmodule

// File: tests/zxmem_cases.txt
# op sel a din opts(disable_7ffd,disable_1ffd) then expected:
# sram_addr sram_we_n dout oe_n ioreqbank access_to_screen; sram byte = low address byte
R Z 0000 00 0 00000 1 01 0 0 0
M R 4123 00 0 14123 1 23 0 0 0
W Z 0001 13 0 00000 1 00 1 0 0
M R C123 00 0 4C123 1 23 0 0 0
M R 0123 00 0 00123 1 00 1 0 0
W Z 0000 80 0 00000 1 00 1 0 0
W Z 0000 01 0 00000 1 00 1 0 0
R Z 0000 00 0 00000 1 80 0 0 0
W P 7FFD 13 0 00000 1 00 1 0 1
M R C0A5 00 0 0C0A5 1 A5 0 0 0
M R 0042 00 0 24042 1 42 0 0 0
M W 0042 00 0 24042 1 00 1 0 0
W P 1FFD 01 0 00000 1 00 1 0 0
M W 0010 00 0 00010 0 00 1 0 0
M R 4011 00 0 04011 1 11 0 0 0
M R 8012 00 0 08012 1 12 0 0 0
M R C013 00 0 0C013 1 13 0 0 0
W P 1FFD 03 0 00000 1 00 1 0 0
M R 0021 00 0 10021 1 21 0 0 0
M R 4022 00 0 14022 1 22 0 0 0
M R 8023 00 0 18023 1 23 0 0 0
M R C024 00 0 1C024 1 24 0 0 0
W P 1FFD 05 0 00000 1 00 1 0 0
M R 0031 00 0 10031 1 31 0 0 0
M R 4032 00 0 14032 1 32 0 0 0
M R 8033 00 0 18033 1 33 0 0 0
M R C034 00 0 0C034 1 34 0 0 0
W P 1FFD 07 0 00000 1 00 1 0 0
M R 0041 00 0 10041 1 41 0 0 0
M R 4042 00 0 1C042 1 42 0 0 0
M R 8043 00 0 18043 1 43 0 0 0
M R C044 00 0 0C044 1 44 0 0 0
W P 1FFD 00 0 00000 1 00 1 0 0
W P 7FFD 27 0 00000 1 00 1 0 1
M R C001 00 0 1C001 1 01 0 0 1
W P 7FFD 03 0 00000 1 00 1 0 1
W P 1FFD 01 0 00000 1 00 1 0 0
M R C002 00 0 1C002 1 02 0 0 1
M R 0003 00 0 20003 1 03 0 0 0
R P 7FFD 00 1 00000 1 00 1 1 1
W P 7FFD 00 1 00000 1 00 1 1 1
M R C003 00 1 1C003 1 03 0 0 1

// File: tests/zxmem_checker.sv
`timescale 1ns/1ns

module zxmem_checker (
   input logic                  clk,
   input logic                  mrst_n,
   input zxmem_pkg::cpu_bus_t   cpu,
   input zxmem_pkg::zxreg_bus_t zxreg,
   input logic                  oe_n,
   input logic                  sram_we_n,
   input logic                  in_boot_mode
);

   int fail_count = 0;   // read by the testbench at the end

   //------------------------------------------------------------
   // sram and cpu side
   //------------------------------------------------------------
   we_idle: assert property (@(posedge clk) disable iff (!mrst_n)
      cpu.mreq_n |-> sram_we_n)
      else begin
         fail_count++;
         $error("sram_we_n low outside a memory cycle");
      end

   // boot rom area lives outside the sram, so nothing is returned
   boot_rom_quiet: assert property (@(posedge clk) disable iff (!mrst_n)
      (in_boot_mode && !cpu.mreq_n && cpu.a[15:14] == 2'b00 && !zxreg.ior) |-> oe_n)
      else begin
         fail_count++;
         $error("oe_n low for slot 0 while in boot mode");
      end

   boot_after_reset: assert property (@(posedge clk) !mrst_n |=> in_boot_mode)
      else begin
         fail_count++;
         $error("in_boot_mode low in the cycle after reset");
      end

endmodule

bind zxmem_top zxmem_checker u_checker (.*);

// File: tests/zxmem_tb.sv
`timescale 1ns/1ns

module zxmem_tb;
   import zxmem_pkg::*;

   logic        clk;
   logic        mrst_n;
   cpu_bus_t    cpu;
   zxreg_bus_t  zxreg;
   port_opts_t  opts;
   logic [7:0]  dout;
   logic        oe_n;
   logic [18:0] sram_addr;
   logic        sram_we_n;
   logic [7:0]  sram_wdata;
   logic [7:0]  sram_rdata;
   logic        ioreqbank;
   logic        access_to_screen;
   logic        in_boot_mode;
   logic [1:0]  timing_mode;
   logic        disable_contention;
   logic        issue2_keyboard_enabled;

   string lines[$];      // case lines, comments stripped
   int    errors  = 0;
   int    checks  = 0;
   int    cycles  = 0;
   int    limit   = 0;   // 0 until the cases are loaded
   int    case_no = 0;

   logic [7:0] conf_exp = 8'h01;   // expected masterconf, boot mode out of reset

   tb_clock_gen u_clk (.clk(clk), .mrst_n(mrst_n));

   zxmem_top DUT (
      .clk(clk), .mrst_n(mrst_n), .cpu(cpu), .zxreg(zxreg), .opts(opts),
      .dout(dout), .oe_n(oe_n), .sram_addr(sram_addr), .sram_we_n(sram_we_n),
      .sram_wdata(sram_wdata), .sram_rdata(sram_rdata), .ioreqbank(ioreqbank),
      .access_to_screen(access_to_screen), .in_boot_mode(in_boot_mode),
      .timing_mode(timing_mode), .disable_contention(disable_contention),
      .issue2_keyboard_enabled(issue2_keyboard_enabled)
   );

   assign sram_rdata = sram_addr[7:0];   // each sram byte holds its low address byte

   task automatic compare_out(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH %s: got %0h, expected %0h (case %0d)", name, got, exp, case_no);
      end
   endtask

   //------------------------------------------------------------
   // one case line: drive, wait, compare
   //------------------------------------------------------------
   task automatic run_case(input string text);
      logic [7:0]  op;
      logic [7:0]  sel;
      logic [15:0] a;
      logic [7:0]  din;
      logic [1:0]  ov;
      logic [18:0] e_addr;
      logic        e_we;
      logic [7:0]  e_dout;
      logic        e_oe;
      logic        e_irb;
      logic        e_scr;
      logic        is_rd;
      logic        is_wr;
      logic [7:0]  wdata;
      int          n;

      n = $sscanf(text, "%c %c %h %h %h %h %h %h %h %h %h",
                  op, sel, a, din, ov, e_addr, e_we, e_dout, e_oe, e_irb, e_scr);
      case_no++;
      if (n != 11) begin
         errors++;
         $display("case %0d could not be parsed: %s", case_no, text);
      end else begin
         is_rd = (op == "R") || (op == "M" && sel == "R");
         is_wr = (op == "W") || (op == "M" && sel == "W");
         wdata = (op == "W") ? din : 8'($urandom);   // don't care unless written
         // masterconf rule, bits 6..3 always, the rest only while not frozen
         if (op == "W" && sel == "Z" && a[7:0] == REG_ADDR_MASTERCONF) begin
            conf_exp[6:3] = din[6:3];
            if (!conf_exp[7]) begin
               conf_exp[7]   = din[7];
               conf_exp[2:0] = din[2:0];
            end
         end
         @(posedge clk);
         cpu.a      <= a;
         cpu.din    <= wdata;
         cpu.mreq_n <= (op != "M");
         cpu.iorq_n <= (sel != "P");
         cpu.rd_n   <= !(is_rd && sel != "Z");
         cpu.wr_n   <= !(is_wr && sel != "Z");
         cpu.m1_n   <= 1'b1;
         zxreg.addr <= a[7:0];                              // register number for Z lines
         zxreg.ior  <= is_rd && sel == "Z";
         zxreg.iow  <= is_wr && sel == "Z";
         opts       <= ov;
         @(posedge clk);
         if (op == "W") begin
            @(posedge clk);   // written value shows one cycle later
         end
         @(negedge clk);      // outputs settled, away from the drive edge
         compare_out("sram_addr", 32'(sram_addr), 32'(e_addr));
         compare_out("sram_we_n", 32'(sram_we_n), 32'(e_we));
         compare_out("dout", 32'(dout), 32'(e_dout));
         compare_out("oe_n", 32'(oe_n), 32'(e_oe));
         compare_out("ioreqbank", 32'(ioreqbank), 32'(e_irb));
         compare_out("access_to_screen", 32'(access_to_screen), 32'(e_scr));
         compare_out("sram_wdata", 32'(sram_wdata), 32'(wdata));   // cpu byte to sram
         // configuration outputs follow the masterconf bits
         compare_out("in_boot_mode", 32'(in_boot_mode), 32'(conf_exp[0]));
         compare_out("timing_mode", 32'(timing_mode), 32'({conf_exp[6], conf_exp[4]}));
         compare_out("disable_contention", 32'(disable_contention), 32'(conf_exp[5]));
         compare_out("issue2_keyboard_enabled", 32'(issue2_keyboard_enabled),
                     32'(conf_exp[3]));
      end
   endtask

   task automatic end_run(input logic timed_out);
      int asserts;

      asserts = DUT.u_checker.fail_count;
      $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asserts);
      if (timed_out || errors != 0 || asserts != 0) begin
         $display("TEST FAILED");
      end else begin
         $display("TEST OK");
      end
      $finish;
   endtask

   // watchdog, 20 cycles per case on top of the reset
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("timeout, cases still running after %0d cycles", cycles);
         end_run(1'b1);
      end
   end

   initial begin
      int    fd;
      string line;

      cpu   <= '1;   // idle bus, strobes high
      zxreg <= '0;
      opts  <= '0;
      void'($urandom(3));
      fd = $fopen("tests/zxmem_cases.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("cannot open tests/zxmem_cases.txt");
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
               lines.push_back(line);
            end
         end
         $fclose(fd);
         limit = 20 * lines.size() + 10;
         wait (mrst_n === 1'b1);
         @(negedge clk);
         compare_out("in_boot_mode", 32'(in_boot_mode), 32'd1);   // boot mode out of reset
         foreach (lines[i]) begin
            run_case(lines[i]);
         end
      end
      end_run(1'b0);
   end

endmodule
